// File: hdl/isa_pkg.sv
package isa_pkg;

	localparam int ir_width = 8;
	localparam int opcode_width = 6; // low bits of ir, top two unused
	localparam int alu_mode_width = 3;

	// --------------------------------------------------
	// opcodes, values follow the existing program images
	// --------------------------------------------------
	typedef enum logic [opcode_width-1:0] {
		LDAC   = 6'd1,
		MVACR  = 6'd4,
		MVACRI = 6'd5,
		MVACRJ = 6'd6,
		MVACRK = 6'd7,
		MVACR1 = 6'd8,
		MVACR2 = 6'd9,
		ADDR1  = 6'd11,
		ADDR2  = 6'd12,
		MULT   = 6'd15, // ac * r
		MULTRI = 6'd16,
		MULTRJ = 6'd17,
		MULTRK = 6'd18,
		SUB    = 6'd19, // ac - r
		SUBRI  = 6'd20,
		SUBRJ  = 6'd21,
		SUBRK  = 6'd22,
		CLRR   = 6'd23,
		CLRAC  = 6'd24,
		CLRTR  = 6'd25,
		INCAC  = 6'd26,
		JPNZ   = 6'd27, // target word follows opcode
		ENDOP  = 6'd28,
		LDACRI = 6'd29,
		LDACRJ = 6'd30,
		LDACRK = 6'd31,
		LDACR3 = 6'd32,
		MVACR3 = 6'd33,
		CLRR1  = 6'd38,
		CLRR2  = 6'd39
	} opcode_t;

	// execute pattern shared by a group of opcodes
	typedef enum logic [3:0] {
		cls_load_mem,  // dmem into ac, three steps
		cls_move,      // ac to a register
		cls_alu,       // register into ac through the alu
		cls_add,       // add, then write back to r1/r2
		cls_clear,
		cls_increment,
		cls_jump,
		cls_end,
		cls_noop
	} instr_class_t;

	typedef enum logic [alu_mode_width-1:0] {
		alu_add  = 3'd0,
		alu_sub  = 3'd1,
		alu_mult = 3'd2,
		alu_pass = 3'd4
	} alu_mode_t;

endpackage

// File: hdl/ctrl_pkg.sv
package ctrl_pkg;

	localparam int bus_width = 4;
	localparam int wen_width = 13;
	localparam int clr_width = 5;

	typedef enum logic [3:0] {
		FETCH1,
		FETCH2,
		FETCH_WAIT, // imem read latency
		FETCH3,
		DECODE,
		EXEC1,
		EXEC_X,
		EXEC2,
		SKIP,       // jump not taken, step over target word
		HALT
	} state_t;

	// --------------------------------------------------
	// bus source select
	// --------------------------------------------------
	typedef enum logic [bus_width-1:0] {
		bus_imem = 4'd0,
		bus_dmem = 4'd1,
		bus_pc   = 4'd2,
		bus_dr   = 4'd3,
		bus_r    = 4'd4,
		bus_ac   = 4'd5,
		bus_tr   = 4'd6,
		bus_r1   = 4'd7,
		bus_r2   = 4'd8,
		bus_ri   = 4'd9,
		bus_rj   = 4'd10,
		bus_rk   = 4'd11,
		bus_r3   = 4'd12
	} bus_src_t;

	// write enable bit positions
	localparam int wen_ar = 12;
	localparam int wen_pc = 11;
	localparam int wen_dr = 10;
	localparam int wen_ir = 9;
	localparam int wen_r  = 8;
	localparam int wen_tr = 7;
	localparam int wen_ac = 6;
	localparam int wen_r1 = 5;
	localparam int wen_r2 = 4;
	localparam int wen_ri = 3;
	localparam int wen_rj = 2;
	localparam int wen_rk = 1;
	localparam int wen_r3 = 0;

	typedef enum logic [1:0] {
		inc_none = 2'd0,
		inc_pc   = 2'd1,
		inc_ac   = 2'd2
	} inc_t;

	// clear bit positions
	localparam int clr_r1 = 4;
	localparam int clr_r2 = 3;
	localparam int clr_r  = 2;
	localparam int clr_ac = 1;
	localparam int clr_tr = 0;

endpackage

// File: hdl/opcode_decoder.sv
`timescale 1ns/1ps

module opcode_decoder
(
	input  logic                              clk,
	input  logic                              reset,
	input  logic [isa_pkg::ir_width-1:0]      ir,
	input  ctrl_pkg::state_t                  state,
	output isa_pkg::instr_class_t             instr_class,
	output ctrl_pkg::bus_src_t                src_sel,
	output logic [ctrl_pkg::wen_width-1:0]    dst_wen,
	output isa_pkg::alu_mode_t                alu_op,
	output logic [ctrl_pkg::clr_width-1:0]    clr_sel
);
	import isa_pkg::*;
	import ctrl_pkg::*;

	typedef struct packed {
		instr_class_t                 cls;
		bus_src_t                     src;
		logic [wen_width-1:0]         dst;
		alu_mode_t                    alu;
		logic [clr_width-1:0]         clr;
	} row_t;

	opcode_t      opcode;
	row_t         row;
	instr_class_t class_q;

	function automatic logic [wen_width-1:0] wen_bit(input int pos);
		wen_bit = '0;
		wen_bit[pos] = 1'b1;
	endfunction

	function automatic logic [clr_width-1:0] clr_bit(input int pos);
		clr_bit = '0;
		clr_bit[pos] = 1'b1;
	endfunction

	assign opcode = opcode_t'(ir[opcode_width-1:0]);

	// --------------------------------------------------
	// opcode table
	// --------------------------------------------------
	always_comb
	begin
		case (opcode)
			LDAC:   row = '{cls_load_mem, bus_dmem, '0, alu_pass, '0};
			MVACR:  row = '{cls_move, bus_ac, wen_bit(wen_r), alu_add, '0};
			MVACRI: row = '{cls_move, bus_ac, wen_bit(wen_ri), alu_add, '0};
			MVACRJ: row = '{cls_move, bus_ac, wen_bit(wen_rj), alu_add, '0};
			MVACRK: row = '{cls_move, bus_ac, wen_bit(wen_rk), alu_add, '0};
			MVACR1: row = '{cls_move, bus_ac, wen_bit(wen_r1), alu_add, '0};
			MVACR2: row = '{cls_move, bus_ac, wen_bit(wen_r2), alu_add, '0};
			MVACR3: row = '{cls_move, bus_ac, wen_bit(wen_r3), alu_add, '0};
			ADDR1:  row = '{cls_add, bus_r1, wen_bit(wen_r1), alu_add, '0}; // sum back to r1
			ADDR2:  row = '{cls_add, bus_r2, wen_bit(wen_r2), alu_add, '0};
			MULT:   row = '{cls_alu, bus_r, wen_bit(wen_ac), alu_mult, '0};
			MULTRI: row = '{cls_alu, bus_ri, wen_bit(wen_ac), alu_mult, '0};
			MULTRJ: row = '{cls_alu, bus_rj, wen_bit(wen_ac), alu_mult, '0};
			MULTRK: row = '{cls_alu, bus_rk, wen_bit(wen_ac), alu_mult, '0};
			SUB:    row = '{cls_alu, bus_r, wen_bit(wen_ac), alu_sub, '0};
			SUBRI:  row = '{cls_alu, bus_ri, wen_bit(wen_ac), alu_sub, '0};
			SUBRJ:  row = '{cls_alu, bus_rj, wen_bit(wen_ac), alu_sub, '0};
			SUBRK:  row = '{cls_alu, bus_rk, wen_bit(wen_ac), alu_sub, '0};
			LDACRI: row = '{cls_alu, bus_ri, wen_bit(wen_ac), alu_pass, '0};
			LDACRJ: row = '{cls_alu, bus_rj, wen_bit(wen_ac), alu_pass, '0};
			LDACRK: row = '{cls_alu, bus_rk, wen_bit(wen_ac), alu_pass, '0};
			LDACR3: row = '{cls_alu, bus_r3, wen_bit(wen_ac), alu_pass, '0};
			CLRR:   row = '{cls_clear, bus_imem, '0, alu_add, clr_bit(clr_r)};
			CLRAC:  row = '{cls_clear, bus_imem, '0, alu_add, clr_bit(clr_ac)};
			CLRTR:  row = '{cls_clear, bus_imem, '0, alu_add, clr_bit(clr_tr)};
			CLRR1:  row = '{cls_clear, bus_imem, '0, alu_add, clr_bit(clr_r1)};
			CLRR2:  row = '{cls_clear, bus_imem, '0, alu_add, clr_bit(clr_r2)};
			INCAC:  row = '{cls_increment, bus_imem, '0, alu_add, '0};
			JPNZ:   row = '{cls_jump, bus_imem, '0, alu_add, '0}; // target read from imem
			ENDOP:  row = '{cls_end, bus_imem, '0, alu_add, '0};
			default: row = '{cls_noop, bus_imem, '0, alu_add, '0};
		endcase
	end

	// the sequencer needs the class while still in DECODE
	assign instr_class = (state == DECODE) ? row.cls : class_q;

	always_ff @(posedge clk)
	begin
		if (reset)
			class_q <= cls_noop;
		else if (state == DECODE)
			class_q <= row.cls;
	end

	always_ff @(posedge clk)
	begin
		if (state == DECODE)
		begin
			src_sel <= row.src;
			dst_wen <= row.dst;
			alu_op  <= row.alu;
			clr_sel <= row.clr;
		end
	end

endmodule

// File: hdl/micro_sequencer.sv
`timescale 1ns/1ps

module micro_sequencer
(
	input  logic                  clk,
	input  logic                  reset,
	input  isa_pkg::instr_class_t instr_class,
	input  logic                  z,
	output ctrl_pkg::state_t      state
);
	import isa_pkg::*;
	import ctrl_pkg::*;

	state_t state_next;

	always_comb
	begin
		case (state)
			FETCH1:     state_next = FETCH2;
			FETCH2:     state_next = FETCH_WAIT;
			FETCH_WAIT: state_next = FETCH3;
			FETCH3:     state_next = DECODE;
			DECODE:
			begin
				// only place z is looked at
				if (instr_class == cls_jump && z)
					state_next = SKIP;
				else
					state_next = EXEC1;
			end
			EXEC1:
			begin
				case (instr_class)
					cls_add:                state_next = EXEC2;
					cls_load_mem, cls_jump: state_next = EXEC_X;
					cls_end:                state_next = HALT;
					default:                state_next = FETCH1;
				endcase
			end
			EXEC_X:     state_next = EXEC2;
			EXEC2:      state_next = FETCH1;
			SKIP:       state_next = FETCH1;
			HALT:       state_next = HALT; // left only by reset
			default:    state_next = FETCH1;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			state <= FETCH1;
		else
			state <= state_next;
	end

endmodule

// File: hdl/control_word_gen.sv
`timescale 1ns/1ps

module control_word_gen
(
	input  logic                           clk,
	input  logic                           reset,
	input  ctrl_pkg::state_t               state,
	input  isa_pkg::instr_class_t          instr_class,
	input  ctrl_pkg::bus_src_t             src_sel,
	input  logic [ctrl_pkg::wen_width-1:0] dst_wen,
	input  isa_pkg::alu_mode_t             alu_op,
	input  logic [ctrl_pkg::clr_width-1:0] clr_sel,
	output logic [ctrl_pkg::wen_width-1:0] write_en,
	output ctrl_pkg::bus_src_t             bus_ld,
	output isa_pkg::alu_mode_t             alu_mode,
	output ctrl_pkg::inc_t                 inc,
	output logic [ctrl_pkg::clr_width-1:0] clr,
	output logic                           end_op
);
	import isa_pkg::*;
	import ctrl_pkg::*;

	logic [wen_width-1:0] wen_next;
	bus_src_t             bus_next;
	inc_t                 inc_next;
	logic [clr_width-1:0] clr_next;
	logic                 end_next;
	logic                 alu_set; // word drives alu_mode

	// --------------------------------------------------
	// control word for the current state
	// --------------------------------------------------
	always_comb
	begin
		wen_next = '0;
		bus_next = bus_imem;
		inc_next = inc_none;
		clr_next = '0;
		end_next = 1'b0;
		alu_set  = 1'b0;
		case (state)
			FETCH1:
			begin
				wen_next[wen_ar] = 1'b1;
				bus_next = bus_pc;
			end
			FETCH2:
			begin
				wen_next[wen_dr] = 1'b1; // opcode word into dr
				inc_next = inc_pc;
			end
			FETCH_WAIT: wen_next[wen_dr] = 1'b1;
			FETCH3:
			begin
				wen_next[wen_ar] = 1'b1;
				wen_next[wen_ir] = 1'b1;
				bus_next = bus_dr;
			end
			EXEC1:
			begin
				case (instr_class)
					cls_move:
					begin
						wen_next = dst_wen;
						bus_next = src_sel; // always ac
					end
					cls_alu, cls_add:
					begin
						wen_next[wen_ac] = 1'b1;
						bus_next = src_sel;
						alu_set = 1'b1;
					end
					cls_load_mem, cls_jump:
					begin
						wen_next[wen_dr] = 1'b1;
						bus_next = src_sel; // dmem or imem
					end
					cls_clear:     clr_next = clr_sel;
					cls_increment: inc_next = inc_ac;
					cls_end:       end_next = 1'b1;
					default:       ;
				endcase
			end
			EXEC_X:
			begin
				if (instr_class == cls_load_mem || instr_class == cls_jump)
				begin
					wen_next[wen_dr] = 1'b1;
					bus_next = src_sel;
				end
			end
			EXEC2:
			begin
				case (instr_class)
					cls_load_mem:
					begin
						wen_next[wen_ac] = 1'b1;
						bus_next = bus_dr;
						alu_set = 1'b1; // pass
					end
					cls_add:
					begin
						wen_next = dst_wen; // writeback r1/r2
						bus_next = bus_ac;
					end
					cls_jump:
					begin
						wen_next[wen_pc] = 1'b1;
						bus_next = bus_dr;
					end
					default: ;
				endcase
			end
			SKIP:    inc_next = inc_pc;
			default: ; // DECODE, HALT give a zero word
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			write_en <= '0;
			bus_ld   <= bus_imem;
			alu_mode <= alu_add;
			inc      <= inc_none;
			clr      <= '0;
			end_op   <= 1'b0;
		end
		else
		begin
			write_en <= wen_next;
			bus_ld   <= bus_next;
			inc      <= inc_next;
			clr      <= clr_next;
			end_op   <= end_next;
			if (alu_set)
				alu_mode <= alu_op; // otherwise keeps last mode
		end
	end

endmodule

// File: hdl/control_unit.sv
`timescale 1ns/1ps

module control_unit
(
	input  logic                           clk,
	input  logic                           reset,
	input  logic [isa_pkg::ir_width-1:0]   ir,
	input  logic                           z,
	output logic [ctrl_pkg::wen_width-1:0] write_en,
	output ctrl_pkg::bus_src_t             bus_ld,
	output isa_pkg::alu_mode_t             alu_mode,
	output ctrl_pkg::inc_t                 inc,
	output logic [ctrl_pkg::clr_width-1:0] clr,
	output logic                           end_op
);
	import isa_pkg::*;
	import ctrl_pkg::*;

	state_t               state;
	instr_class_t         instr_class;
	bus_src_t             src_sel;
	logic [wen_width-1:0] dst_wen;
	alu_mode_t            alu_op;
	logic [clr_width-1:0] clr_sel;

	opcode_decoder opcode_decoder_i
	(
		.clk         (clk),
		.reset       (reset),
		.ir          (ir),
		.state       (state),
		.instr_class (instr_class),
		.src_sel     (src_sel),
		.dst_wen     (dst_wen),
		.alu_op      (alu_op),
		.clr_sel     (clr_sel)
	);

	micro_sequencer micro_sequencer_i
	(
		.clk         (clk),
		.reset       (reset),
		.instr_class (instr_class),
		.z           (z),
		.state       (state)
	);

	control_word_gen control_word_gen_i
	(
		.clk         (clk),
		.reset       (reset),
		.state       (state),
		.instr_class (instr_class),
		.src_sel     (src_sel),
		.dst_wen     (dst_wen),
		.alu_op      (alu_op),
		.clr_sel     (clr_sel),
		.write_en    (write_en),
		.bus_ld      (bus_ld),
		.alu_mode    (alu_mode),
		.inc         (inc),
		.clr         (clr),
		.end_op      (end_op)
	);

endmodule

// File: testbench/control_unit_assert.sv
`timescale 1ns/1ps

module control_unit_assert
(
	input logic                           clk,
	input logic                           reset,
	input logic [isa_pkg::ir_width-1:0]   ir,
	input logic                           z,
	input logic [ctrl_pkg::wen_width-1:0] write_en,
	input ctrl_pkg::bus_src_t             bus_ld,
	input isa_pkg::alu_mode_t             alu_mode,
	input ctrl_pkg::inc_t                 inc,
	input logic [ctrl_pkg::clr_width-1:0] clr,
	input logic                           end_op
);
	import isa_pkg::*;
	import ctrl_pkg::*;

	typedef enum {k_load, k_move, k_alu, k_add, k_clear, k_inc, k_jump, k_end, k_noop} kind_t;

	int                   fail_count = 0;
	int                   step = 0;       // 0 FETCH1, 4 decode, execute from 5
	logic                 halted = 1'b0;
	logic                 armed = 1'b0;   // set by the first reset edge
	logic                 taken = 1'b0;   // jump skipped, z was 1
	kind_t                kind = k_noop;
	int                   opnd = 0;       // wen bit of the register operand
	int                   cbit = 0;
	alu_mode_t            mode = alu_add;
	logic [5:0]           op;
	kind_t                d_kind;
	int                   d_dst;
	int                   d_cbit;
	alu_mode_t            d_mode;
	logic [wen_width-1:0] w_wen;
	bus_src_t             w_bus;
	inc_t                 w_inc;
	logic [clr_width-1:0] w_clr;
	logic                 w_end;
	logic                 w_set;          // word drives alu_mode
	alu_mode_t            w_alu;
	logic [wen_width-1:0] exp_wen;
	bus_src_t             exp_bus;
	alu_mode_t            exp_alu;
	inc_t                 exp_inc;
	logic [clr_width-1:0] exp_clr;
	logic                 exp_end;

	function automatic int exec_len(input kind_t k, input logic skip);
		case (k)
			k_add:   return 2;
			k_load:  return 3;
			k_jump:  return skip ? 1 : 3;
			default: return 1;
		endcase
	endfunction

	function automatic bus_src_t reg_bus(input int wbit);
		case (wbit)
			wen_r:   return bus_r;
			wen_ri:  return bus_ri;
			wen_rj:  return bus_rj;
			wen_rk:  return bus_rk;
			wen_r1:  return bus_r1;
			wen_r2:  return bus_r2;
			default: return bus_r3;
		endcase
	endfunction

	function automatic void count_failure(input string what);
		fail_count = fail_count + 1;
		$error("[FAIL] %0t %s", $time, what);
	endfunction

	// --------------------------------------------------
	// reference decode of the opcode field
	// --------------------------------------------------
	assign op = ir[opcode_width-1:0];

	always_comb
	begin
		case (op)
			LDAC:                                                   d_kind = k_load;
			MVACR, MVACRI, MVACRJ, MVACRK, MVACR1, MVACR2, MVACR3: d_kind = k_move;
			MULT, MULTRI, MULTRJ, MULTRK, SUB, SUBRI, SUBRJ, SUBRK: d_kind = k_alu;
			LDACRI, LDACRJ, LDACRK, LDACR3:                         d_kind = k_alu;
			ADDR1, ADDR2:                                           d_kind = k_add;
			CLRR, CLRAC, CLRTR, CLRR1, CLRR2:                       d_kind = k_clear;
			INCAC:                                                  d_kind = k_inc;
			JPNZ:                                                   d_kind = k_jump;
			ENDOP:                                                  d_kind = k_end;
			default:                                                d_kind = k_noop;
		endcase
		case (op)
			MVACR, MULT, SUB:              d_dst = wen_r;
			MVACRI, MULTRI, SUBRI, LDACRI: d_dst = wen_ri;
			MVACRJ, MULTRJ, SUBRJ, LDACRJ: d_dst = wen_rj;
			MVACRK, MULTRK, SUBRK, LDACRK: d_dst = wen_rk;
			MVACR1, ADDR1:                 d_dst = wen_r1;
			MVACR2, ADDR2:                 d_dst = wen_r2;
			default:                       d_dst = wen_r3; // MVACR3, LDACR3
		endcase
		case (op)
			MULT, MULTRI, MULTRJ, MULTRK:   d_mode = alu_mult;
			SUB, SUBRI, SUBRJ, SUBRK:       d_mode = alu_sub;
			LDACRI, LDACRJ, LDACRK, LDACR3: d_mode = alu_pass;
			default:                        d_mode = alu_add;
		endcase
		case (op)
			CLRR:    d_cbit = clr_r;
			CLRAC:   d_cbit = clr_ac;
			CLRTR:   d_cbit = clr_tr;
			CLRR1:   d_cbit = clr_r1;
			default: d_cbit = clr_r2;
		endcase
	end

	// --------------------------------------------------
	// expected word for the current step
	// --------------------------------------------------
	always_comb
	begin
		w_wen = '0;
		w_bus = bus_imem;
		w_inc = inc_none;
		w_clr = '0;
		w_end = 1'b0;
		w_set = 1'b0;
		w_alu = mode;
		if (!halted)
		begin
			case (step)
				0:
				begin
					w_wen[wen_ar] = 1'b1;
					w_bus = bus_pc;
				end
				1:
				begin
					w_wen[wen_dr] = 1'b1;
					w_inc = inc_pc;
				end
				2: w_wen[wen_dr] = 1'b1;
				3:
				begin
					w_wen[wen_ar] = 1'b1;
					w_wen[wen_ir] = 1'b1;
					w_bus = bus_dr;
				end
				4: ; // decode word is empty
				default:
				begin
					case (kind)
						k_move:
						begin
							w_wen = wen_width'(1 << opnd);
							w_bus = bus_ac;
						end
						k_alu, k_add:
						begin
							if (step == 5)
							begin
								w_wen[wen_ac] = 1'b1;
								w_bus = reg_bus(opnd);
								w_set = 1'b1;
							end
							else
							begin
								w_wen = wen_width'(1 << opnd); // sum back to r1/r2
								w_bus = bus_ac;
							end
						end
						k_load:
						begin
							if (step == 7)
							begin
								w_wen[wen_ac] = 1'b1;
								w_bus = bus_dr;
								w_alu = alu_pass;
								w_set = 1'b1;
							end
							else
							begin
								w_wen[wen_dr] = 1'b1;
								w_bus = bus_dmem;
							end
						end
						k_jump:
						begin
							if (taken)
								w_inc = inc_pc; // step over the target word
							else if (step == 7)
							begin
								w_wen[wen_pc] = 1'b1;
								w_bus = bus_dr;
							end
							else
								w_wen[wen_dr] = 1'b1; // target word from imem
						end
						k_clear: w_clr = clr_width'(1 << cbit);
						k_inc:   w_inc = inc_ac;
						k_end:   w_end = 1'b1;
						default: ;
					endcase
				end
			endcase
		end
	end

	always @(posedge clk)
	begin
		if (reset)
		begin
			armed   <= 1'b1;
			halted  <= 1'b0;
			step    <= 0;
			exp_wen <= '0;
			exp_bus <= bus_imem;
			exp_alu <= alu_add;
			exp_inc <= inc_none;
			exp_clr <= '0;
			exp_end <= 1'b0;
		end
		else
		begin
			exp_wen <= w_wen;
			exp_bus <= w_bus;
			exp_inc <= w_inc;
			exp_clr <= w_clr;
			exp_end <= w_end;
			if (w_set)
				exp_alu <= w_alu; // mode holds otherwise
			if (!halted)
			begin
				if (step == 4)
				begin
					kind  <= d_kind;
					opnd  <= d_dst;
					mode  <= d_mode;
					cbit  <= d_cbit;
					taken <= d_kind == k_jump && z;
					step  <= 5;
				end
				else if (step == 4 + exec_len(kind, taken))
				begin
					halted <= kind == k_end; // stays until reset
					step   <= 0;
				end
				else
					step <= step + 1;
			end
		end
	end

	a_write_en: assert property (@(posedge clk) armed |-> write_en == exp_wen)
		else count_failure($sformatf("write_en %h, expected %h",
			$sampled(write_en), $sampled(exp_wen)));
	a_bus_ld: assert property (@(posedge clk) armed |-> bus_ld == exp_bus)
		else count_failure($sformatf("bus_ld %0d, expected %0d",
			$sampled(bus_ld), $sampled(exp_bus)));
	a_alu_mode: assert property (@(posedge clk) armed |-> alu_mode == exp_alu)
		else count_failure($sformatf("alu_mode %0d, expected %0d",
			$sampled(alu_mode), $sampled(exp_alu)));
	a_inc: assert property (@(posedge clk) armed |-> inc == exp_inc)
		else count_failure($sformatf("inc %0d, expected %0d",
			$sampled(inc), $sampled(exp_inc)));
	a_clr: assert property (@(posedge clk) armed |-> clr == exp_clr)
		else count_failure($sformatf("clr %b, expected %b",
			$sampled(clr), $sampled(exp_clr)));
	a_end_op: assert property (@(posedge clk) armed |-> end_op == exp_end)
		else count_failure($sformatf("end_op %b, expected %b",
			$sampled(end_op), $sampled(exp_end)));
	a_end_pulse: assert property (@(posedge clk) armed && end_op |=> !end_op)
		else count_failure("end_op high for more than one cycle");

endmodule

bind control_unit control_unit_assert control_unit_assert_i
(
	.clk      (clk),
	.reset    (reset),
	.ir       (ir),
	.z        (z),
	.write_en (write_en),
	.bus_ld   (bus_ld),
	.alu_mode (alu_mode),
	.inc      (inc),
	.clr      (clr),
	.end_op   (end_op)
);

// File: testbench/tb_control_unit.sv
`timescale 1ns/1ps

module tb_control_unit;
	import isa_pkg::*;
	import ctrl_pkg::*;

	// about 40 instructions of up to 9 cycles, plus reset and halt window
	localparam int cycle_limit = 400;

	logic                 clk;
	logic                 reset;
	logic [ir_width-1:0]  ir;
	logic                 z;
	logic [wen_width-1:0] write_en;
	bus_src_t             bus_ld;
	alu_mode_t            alu_mode;
	inc_t                 inc;
	logic [clr_width-1:0] clr;
	logic                 end_op;

	int                      seed = 32'h310c_07e2;
	int                      cycle_count = 0;
	int                      tests_run = 0;
	int                      tests_failed = 0;
	logic [opcode_width-1:0] prog[$]; // opcodes of the current test

	control_unit control_unit_i
	(
		.clk      (clk),
		.reset    (reset),
		.ir       (ir),
		.z        (z),
		.write_en (write_en),
		.bus_ld   (bus_ld),
		.alu_mode (alu_mode),
		.inc      (inc),
		.clr      (clr),
		.end_op   (end_op)
	);

	always #4 clk = ~clk;

	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit)
		begin
			$display("timeout: instruction stream not finished after %0d cycles", cycle_limit);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	function automatic int failures();
		return control_unit_i.control_unit_assert_i.fail_count;
	endfunction

	function automatic logic fetch1_word();
		return write_en == wen_width'(1 << wen_ar) && bus_ld == bus_pc;
	endfunction

	function automatic logic fetch2_word();
		return write_en == wen_width'(1 << wen_dr) && inc == inc_pc;
	endfunction

	// next opcode goes in once the FETCH2 word has been seen
	task automatic issue(input logic [opcode_width-1:0] op, output logic z_used);
		int rnd;
		do
			@(posedge clk);
		while (!fetch2_word());
		rnd = $random(seed);
		ir <= {rnd[2:1], op}; // top bits are don't care
		z <= rnd[0];
		z_used = rnd[0];
	endtask

	task automatic wait_next_fetch();
		do
			@(posedge clk);
		while (!fetch1_word() && !end_op);
	endtask

	task automatic run_list();
		logic z_used;
		foreach (prog[i])
			issue(prog[i], z_used);
		wait_next_fetch();
	endtask

	task automatic report_test(input string name, input int fails_before);
		int fails;
		fails = failures() - fails_before;
		tests_run++;
		if (fails == 0)
			$display("test %s: passed", name);
		else
		begin
			tests_failed++;
			$display("test %s: %0d assertion failures", name, fails);
		end
	endtask

	initial
	begin
		int         fails_before;
		int         n;
		logic       z_used;
		logic [1:0] z_seen;
		clk = 1'b0;
		reset = 1'b1;
		ir = '0;
		z = 1'b0;
		repeat (4) @(posedge clk);
		reset <= 1'b0;

		fails_before = failures();
		prog = {MVACR, MVACRI, MVACRJ, MVACRK, MVACR1, MVACR2, MVACR3};
		run_list();
		report_test("moves", fails_before);

		fails_before = failures();
		prog = {MULT, MULTRI, MULTRJ, MULTRK, SUB, SUBRI, SUBRJ, SUBRK,
			LDACRI, LDACRJ, LDACRK, LDACR3};
		run_list();
		report_test("alu ops", fails_before);

		fails_before = failures();
		prog = {CLRR, CLRAC, CLRTR, CLRR1, CLRR2, INCAC, 6'd2}; // 2 is undefined
		run_list();
		report_test("clears, increment, noop", fails_before);

		fails_before = failures();
		prog = {ADDR1, ADDR2, LDAC};
		run_list();
		report_test("add and load", fails_before);

		// --------------------------------------------------
		// jpnz until both z values have been used
		// --------------------------------------------------
		fails_before = failures();
		z_seen = 2'b00;
		n = 0;
		while (z_seen != 2'b11 && n < 8)
		begin
			issue(JPNZ, z_used);
			z_seen[z_used] = 1'b1;
			n++;
		end
		wait_next_fetch();
		report_test("jump", fails_before);

		fails_before = failures();
		prog = {ENDOP};
		run_list();
		repeat (10) @(posedge clk); // halted outputs must stay zero
		report_test("end of program", fails_before);

		fails_before = failures();
		reset <= 1'b1;
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		prog = {INCAC};
		run_list();
		report_test("reset after halt", fails_before);

		$display("%0d tests run, %0d failed, %0d assertion failures",
			tests_run, tests_failed, failures());
		if (failures() == 0 && tests_failed == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

// File: files.f
hdl/isa_pkg.sv
hdl/ctrl_pkg.sv
hdl/opcode_decoder.sv
hdl/micro_sequencer.sv
hdl/control_word_gen.sv
hdl/control_unit.sv
testbench/control_unit_assert.sv
testbench/tb_control_unit.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_control_unit
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
SIM_ARGS  ?= +verilator+error+limit+1000

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	grep -q "^NO ERRORS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
